/* verilog/regfile_cfg.svh */
`ifndef REGFILE_CFG_SVH
`define REGFILE_CFG_SVH

// one machine word per entry
`define RF_ENTRY_WIDTH 32

// architectural entries, a power of two
`define RF_N_ENTRIES 16

// operand fetch reads two sources at once
`define RF_N_READ_PORTS 2
`define RF_N_WRITE_PORTS 2

`endif

/* verilog/rf_types_pkg.sv */
`default_nettype none

`include "regfile_cfg.svh"

package rf_types_pkg;

    // entry index
    typedef logic [$clog2(`RF_N_ENTRIES)-1:0] reg_addr_t;

    // one entry value
    typedef logic [`RF_ENTRY_WIDTH-1:0] reg_data_t;

    // whole register contents, entry 0 in the low word
    typedef reg_data_t [`RF_N_ENTRIES-1:0] reg_array_t;

endpackage

`default_nettype wire

/* verilog/rf_chan_pkg.sv */
`default_nettype none

package rf_chan_pkg;
    import rf_types_pkg::*;

    // writeback channel payload
    typedef struct packed {
        reg_addr_t dest;
        reg_data_t data;
    } wb_req_t;

    // operand read request, both sources together
    typedef struct packed {
        reg_addr_t src_a;
        reg_addr_t src_b;
    } rd_req_t;

    // operand read response
    typedef struct packed {
        reg_data_t opnd_a;
        reg_data_t opnd_b;
    } rd_rsp_t;

endpackage

`default_nettype wire

/* verilog/hs_slave.sv */
`default_nettype none
`timescale 1ns/100ps

module hs_slave #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req,
    input  payload_t payload,
    output logic     ack,
    output logic     fire,
    output payload_t fire_payload
);

    // transfer underway, cleared one edge after ack has dropped
    logic pending;

    // one fire per transfer, only from the idle phase
    assign fire = req && !ack && !pending;

    // requester keeps the payload stable while req is high
    assign fire_payload = payload;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ack     <= 1'b0;
            pending <= 1'b0;
        end else if (fire) begin
            ack     <= 1'b1;
            pending <= 1'b1;
        end else begin
            // return to zero: ack follows req down
            if (!req) begin
                ack <= 1'b0;
            end
            if (!req && !ack) begin
                pending <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* verilog/regfile.sv */
`default_nettype none
`timescale 1ns/100ps

`include "regfile_cfg.svh"

module regfile #(
    parameter int N_ENTRIES     = `RF_N_ENTRIES,
    parameter int N_READ_PORTS  = `RF_N_READ_PORTS,
    parameter int N_WRITE_PORTS = `RF_N_WRITE_PORTS
) (
    input  logic                                         clk,
    input  logic                                         rst_n,
    input  logic [N_WRITE_PORTS-1:0]                     wr_en,
    input  rf_chan_pkg::wb_req_t [N_WRITE_PORTS-1:0]     wr_req,
    input  rf_types_pkg::reg_addr_t [N_READ_PORTS-1:0]   rd_addr,
    output rf_types_pkg::reg_data_t [N_READ_PORTS-1:0]   rd_data,
    input  logic                                         flush
);
    import rf_types_pkg::*;

    // storage
    reg_data_t [N_ENTRIES-1:0] entries;

    // per entry: which write ports address it
    logic [N_ENTRIES-1:0][N_WRITE_PORTS-1:0] hit;

    // per entry write enable and selected write data
    logic [N_ENTRIES-1:0] we;
    reg_data_t [N_ENTRIES-1:0] din;

    // decode and priority select
    always_comb begin
        hit = '0;
        din = '0;
        for (int e = 0; e < N_ENTRIES; e++) begin
            // walk from the highest port down so the lowest port wins
            for (int p = N_WRITE_PORTS - 1; p >= 0; p--) begin
                if (wr_en[p] && (wr_req[p].dest == reg_addr_t'(e))) begin
                    hit[e][p] = 1'b1;
                    din[e]    = wr_req[p].data;
                end
            end
        end
    end

    always_comb begin
        for (int e = 0; e < N_ENTRIES; e++) begin
            we[e] = |hit[e];
        end
    end

    // flush overrides any write on the same edge
    always_ff @(posedge clk) begin
        if (!rst_n || flush) begin
            entries <= '0;
        end else begin
            for (int e = 0; e < N_ENTRIES; e++) begin
                if (we[e]) begin
                    entries[e] <= din[e];
                end
            end
        end
    end

    // read ports, combinational from current contents
    always_comb begin
        for (int r = 0; r < N_READ_PORTS; r++) begin
            rd_data[r] = entries[rd_addr[r]];
        end
    end

endmodule

`default_nettype wire

/* verilog/operand_fetch.sv */
`default_nettype none
`timescale 1ns/100ps

`include "regfile_cfg.svh"

module operand_fetch (
    input  logic                                            clk,
    input  logic                                            rst_n,
    input  logic                                            req,
    input  rf_chan_pkg::rd_req_t                            payload,
    output logic                                            ack,
    output rf_chan_pkg::rd_rsp_t                            rsp,
    output rf_types_pkg::reg_addr_t [`RF_N_READ_PORTS-1:0] rd_addr,
    input  rf_types_pkg::reg_data_t [`RF_N_READ_PORTS-1:0] rd_data
);
    import rf_chan_pkg::*;

    logic    fire;
    rd_req_t src;

    hs_slave #(
        .payload_t (rd_req_t)
    ) u_rd_hs (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (req),
        .payload      (payload),
        .ack          (ack),
        .fire         (fire),
        .fire_payload (src)
    );

    // port 0 reads source a, port 1 source b
    assign rd_addr[0] = src.src_a;
    assign rd_addr[1] = src.src_b;

    // captured on fire, so a write on the same edge is not seen
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rsp <= '0;
        end else if (fire) begin
            rsp.opnd_a <= rd_data[0];
            rsp.opnd_b <= rd_data[1];
        end
    end

endmodule

`default_nettype wire

/* verilog/regfile_unit.sv */
`default_nettype none
`timescale 1ns/100ps

`include "regfile_cfg.svh"

module regfile_unit (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 flush,
    input  logic                 wb0_req,
    input  rf_chan_pkg::wb_req_t wb0_payload,
    output logic                 wb0_ack,
    input  logic                 wb1_req,
    input  rf_chan_pkg::wb_req_t wb1_payload,
    output logic                 wb1_ack,
    input  logic                 rd_req,
    input  rf_chan_pkg::rd_req_t rd_payload,
    output logic                 rd_ack,
    output rf_chan_pkg::rd_rsp_t rd_rsp
);
    import rf_types_pkg::*;
    import rf_chan_pkg::*;

    // write ports, one per writeback channel
    logic [`RF_N_WRITE_PORTS-1:0] wr_en;
    wb_req_t [`RF_N_WRITE_PORTS-1:0] wr_req;

    // read ports
    reg_addr_t [`RF_N_READ_PORTS-1:0] rd_addr;
    reg_data_t [`RF_N_READ_PORTS-1:0] rd_data;

    // writeback 0 has priority on a same-entry collision
    hs_slave #(
        .payload_t (wb_req_t)
    ) u_wb0_hs (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (wb0_req),
        .payload      (wb0_payload),
        .ack          (wb0_ack),
        .fire         (wr_en[0]),
        .fire_payload (wr_req[0])
    );

    hs_slave #(
        .payload_t (wb_req_t)
    ) u_wb1_hs (
        .clk          (clk),
        .rst_n        (rst_n),
        .req          (wb1_req),
        .payload      (wb1_payload),
        .ack          (wb1_ack),
        .fire         (wr_en[1]),
        .fire_payload (wr_req[1])
    );

    regfile #(
        .N_ENTRIES     (`RF_N_ENTRIES),
        .N_READ_PORTS  (`RF_N_READ_PORTS),
        .N_WRITE_PORTS (`RF_N_WRITE_PORTS)
    ) u_regfile (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_req  (wr_req),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .flush   (flush)
    );

    operand_fetch u_operand_fetch (
        .clk     (clk),
        .rst_n   (rst_n),
        .req     (rd_req),
        .payload (rd_payload),
        .ack     (rd_ack),
        .rsp     (rd_rsp),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

endmodule

`default_nettype wire

/* bench/regfile_unit_tb.sv */
`default_nettype none
`timescale 1ns/100ps

`include "regfile_cfg.svh"

module regfile_unit_tb;
    import rf_types_pkg::*;
    import rf_chan_pkg::*;

    localparam int N_XFER   = 400;
    localparam int MAX_GAP  = 4;
    // gap, raise, fire, ack seen, ack falls, ack seen low
    localparam int XFER_CYC = MAX_GAP + 5;
    localparam int LIMIT_NS = (5 + N_XFER * XFER_CYC + 100) * 10;

    logic       clk;
    logic       rst_n;
    logic       flush;
    // channel 0 and 1 are writebacks, channel 2 is the operand read
    logic [2:0] req;
    wire  [2:0] ack;
    wb_req_t    wb_payload [2];
    rd_req_t    rd_payload;
    rd_rsp_t    rd_rsp;

    // reference model state
    reg_array_t model;
    rd_rsp_t    exp_rsp;
    logic [2:0] exp_ack;
    logic [2:0] ack_q;
    int         n_ack [3];
    int         n_collide;
    int         n_rd_wr;
    int         n_flush_wr;
    logic       traffic_done;

    regfile_unit UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .flush       (flush),
        .wb0_req     (req[0]),
        .wb0_payload (wb_payload[0]),
        .wb0_ack     (ack[0]),
        .wb1_req     (req[1]),
        .wb1_payload (wb_payload[1]),
        .wb1_ack     (ack[1]),
        .rd_req      (req[2]),
        .rd_payload  (rd_payload),
        .rd_ack      (ack[2]),
        .rd_rsp      (rd_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("RESULT: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    // few hot entries, so both writeback ports often collide
    function automatic reg_addr_t pick_dest();
        return reg_addr_t'(4 * $urandom_range(3, 0) + 1);
    endfunction

    function automatic reg_addr_t pick_src();
        if ($urandom_range(3, 0) == 0) begin
            return reg_addr_t'($urandom_range(`RF_N_ENTRIES - 1, 0));
        end
        return pick_dest();
    endfunction

    // one four-phase transfer, payload driven alongside req
    task automatic handshake(input logic [1:0] ch);
        req[ch] <= 1'b1;
        @(posedge clk);
        while (!ack[ch]) @(posedge clk);
        req[ch] <= 1'b0;
        @(posedge clk);
        while (ack[ch]) @(posedge clk);
    endtask

    task automatic wb_requester(input logic [1:0] ch);
        wb_req_t p;
        for (int i = 0; i < N_XFER; i++) begin
            repeat ($urandom_range(MAX_GAP, 0)) @(posedge clk);
            p.dest = pick_dest();
            p.data = $urandom();
            wb_payload[ch[0]] <= p;
            handshake(ch);
        end
    endtask

    task automatic rd_requester();
        rd_req_t p;
        for (int i = 0; i < N_XFER; i++) begin
            repeat ($urandom_range(MAX_GAP, 0)) @(posedge clk);
            p.src_a = pick_src();
            p.src_b = pick_src();
            rd_payload <= p;
            handshake(2'd2);
        end
    endtask

    task automatic pulse_flush();
        while (!traffic_done) begin
            @(posedge clk);
            flush <= ($urandom_range(39, 0) == 0);
        end
        flush <= 1'b0;
    endtask

    task automatic check_ack(input logic [1:0] c);
        assert (ack[c] === exp_ack[c]) else
            report_fail($sformatf("Fail %0t: ack of channel %0d is %b, expected %b",
                $time, c, ack[c], exp_ack[c]));
    endtask

    task automatic check_count(input logic [1:0] c);
        assert (n_ack[c] == N_XFER) else
            report_fail($sformatf("Error: channel %0d gave %0d acks for %0d requests",
                c, n_ack[c], N_XFER));
    endtask

    // model sees the values that stood before each edge
    always @(posedge clk) begin
        logic [2:0] fire;
        logic       src_hit;
        if (!rst_n) begin
            model   = '0;
            exp_rsp = '0;
            exp_ack = '0;
            ack_q   = '0;
        end else begin
            check_ack(2'd0);
            check_ack(2'd1);
            check_ack(2'd2);
            assert (rd_rsp === exp_rsp) else
                report_fail($sformatf("Fail %0t: rd_rsp is %h %h, expected %h %h", $time,
                    rd_rsp.opnd_a, rd_rsp.opnd_b, exp_rsp.opnd_a, exp_rsp.opnd_b));

            // rising acks as the DUT gives them
            for (int c = 0; c < 3; c++) begin
                if (ack[c] && !ack_q[c]) n_ack[c]++;
            end
            ack_q = ack;

            // transfer starts on req while the modelled ack is low
            fire    = req & ~exp_ack;
            exp_ack = fire | (exp_ack & req);

            src_hit = 1'b0;
            for (int w = 0; w < 2; w++) begin
                if (fire[w] && (wb_payload[w].dest == rd_payload.src_a ||
                                wb_payload[w].dest == rd_payload.src_b)) begin
                    src_hit = 1'b1;
                end
            end
            if (fire[2] && src_hit) n_rd_wr++;
            if (fire[0] && fire[1] && wb_payload[0].dest == wb_payload[1].dest) n_collide++;
            if (flush && (fire[0] || fire[1])) n_flush_wr++;

            // snapshot first, then writes with port 0 last so it wins
            if (fire[2]) begin
                exp_rsp.opnd_a = model[rd_payload.src_a];
                exp_rsp.opnd_b = model[rd_payload.src_b];
            end
            if (flush) begin
                model = '0;
            end else begin
                if (fire[1]) model[wb_payload[1].dest] = wb_payload[1].data;
                if (fire[0]) model[wb_payload[0].dest] = wb_payload[0].data;
            end
        end
    end

    initial begin
        #(LIMIT_NS);
        $display("Error: the run hung, no end of traffic after %0t", $time);
        $display("RESULT: FAIL");
        $fatal(1, "watchdog expired");
    end

    initial begin
        void'($urandom(39));
        rst_n         = 1'b0;
        flush         = 1'b0;
        req           = '0;
        wb_payload[0] = '0;
        wb_payload[1] = '0;
        rd_payload    = '0;
        traffic_done  = 1'b0;
        n_ack         = '{0, 0, 0};
        n_collide     = 0;
        n_rd_wr       = 0;
        n_flush_wr    = 0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        fork
            begin
                fork
                    wb_requester(2'd0);
                    wb_requester(2'd1);
                    rd_requester();
                join
                traffic_done = 1'b1;
            end
            pulse_flush();
        join
        repeat (3) @(posedge clk);

        check_count(2'd0);
        check_count(2'd1);
        check_count(2'd2);
        assert (n_collide > 0) else
            report_fail("Error: both writebacks never hit one entry on the same edge");
        assert (n_rd_wr > 0) else
            report_fail("Error: no read ever fired on the edge of a write to its source");
        assert (n_flush_wr > 0) else
            report_fail("Error: no flush ever met a write on the same edge");
        $display("collisions %0d, read-write overlaps %0d, flushed writes %0d",
            n_collide, n_rd_wr, n_flush_wr);
        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* flist.f */
+incdir+verilog
verilog/rf_types_pkg.sv
verilog/rf_chan_pkg.sv
verilog/hs_slave.sv
verilog/regfile.sv
verilog/operand_fetch.sv
verilog/regfile_unit.sv
bench/regfile_unit_tb.sv

/* Makefile */
# Verilator build and run of the register file testbench

SIM := obj_dir/Vregfile_unit_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): flist.f $(wildcard verilog/*.sv verilog/*.svh bench/*.sv)
	verilator --binary --timing --assert \
		--top-module regfile_unit_tb -f flist.f

# the simulator exits non-zero on any $fatal
run: $(SIM)
	./$(SIM)

clean:
	rm -rf obj_dir
